// File: logic/lsu_pkg.sv
// Shared definitions of the load/store unit
// Widths, counter and offset types, access size encoding
// EX request, bus address phase and WB control structs
`default_nettype none

package lsu_pkg;

  //////////////////////////////
  // Widths and limits
  //////////////////////////////

  localparam int ADDR_W         = 32;
  localparam int DATA_W         = 32;
  localparam int BYTES_PER_WORD = 4;
  // Most bus transfers in flight at once
  localparam int MAX_OUTSTANDING = 2;
  localparam int OFFSET_W       = $clog2(BYTES_PER_WORD);
  // Counter must also hold the full value
  localparam int CNT_W          = $clog2(MAX_OUTSTANDING + 1);

  typedef logic [ADDR_W-1:0]         addr_t;
  typedef logic [DATA_W-1:0]         data_t;
  typedef logic [BYTES_PER_WORD-1:0] be_t;
  typedef logic [OFFSET_W-1:0]       offset_t;
  typedef logic [CNT_W-1:0]          cnt_t;

  // Access size, same encoding as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } size_e;

  //////////////////////////////
  // Structs
  //////////////////////////////

  // Load or store as presented by EX
  typedef struct packed {
    addr_t operand_a;
    addr_t operand_b;
    logic  we;
    size_e size;
    logic  sext;
    data_t wdata;
  } lsu_req_t;

  // Address phase of one word-aligned bus transfer
  typedef struct packed {
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;
  } bus_req_t;

  // Control kept per transfer until its response
  typedef struct packed {
    size_e   size;
    logic    sext;
    offset_t offset;
    logic    last;  // Final transfer of the access
    logic    we;
  } wb_ctrl_t;

endpackage

`default_nettype wire

// File: logic/lsu_request_gen.sv
// Bus request generation of the load/store unit
// Address adder, split detection and tracking
// Byte enables and write data rotation into the addressed lanes
`default_nettype none

module lsu_request_gen (
  input  logic              clk,
  input  logic              rst_n,
  input  lsu_pkg::lsu_req_t ex_req_i,
  input  logic              valid_0_i,
  input  logic              accepted_i,
  output lsu_pkg::bus_req_t bus_trans_o,
  output logic              split_o,
  output lsu_pkg::offset_t  first_offset_o
);
  import lsu_pkg::*;

  addr_t                       addr;
  addr_t                       word_addr;
  offset_t                     offset;
  be_t                         size_mask;
  logic [2*BYTES_PER_WORD-1:0] be_wide;
  data_t                       wdata_rot;
  // Second address phase of a split access in progress
  logic                        split_q;

  assign addr      = ex_req_i.operand_a + ex_req_i.operand_b;
  assign offset    = addr[OFFSET_W-1:0];
  assign word_addr = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

  // Offset of the access itself, also during the second phase
  assign first_offset_o = offset;

  //////////////////////////////
  // Split detection
  //////////////////////////////

  // Word off a boundary, or halfword in the top lane
  always_comb begin
    split_o = 1'b0;
    if (valid_0_i && !split_q) begin
      case (ex_req_i.size)
        SIZE_WORD: split_o = (offset != '0);
        SIZE_HALF: split_o = (&offset);
        default:   split_o = 1'b0;
      endcase
    end
  end

  // Set on first acceptance, cleared on second
  // Dropped valid kills a pending second phase
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!valid_0_i) begin
      split_q <= 1'b0;
    end else if (accepted_i) begin
      split_q <= split_o;
    end
  end

  //////////////////////////////
  // Byte enables
  //////////////////////////////

  always_comb begin
    case (ex_req_i.size)
      SIZE_BYTE: size_mask = 4'b0001;
      SIZE_HALF: size_mask = 4'b0011;
      default:   size_mask = 4'b1111;
    endcase
  end

  // Lanes past the word end spill into the upper half
  assign be_wide = {{BYTES_PER_WORD{1'b0}}, size_mask} << offset;

  // Rotate left by the byte offset
  // Lanes that wrap are the ones the second phase writes
  always_comb begin
    case (offset)
      2'd1:    wdata_rot = {ex_req_i.wdata[23:0], ex_req_i.wdata[31:24]};
      2'd2:    wdata_rot = {ex_req_i.wdata[15:0], ex_req_i.wdata[31:16]};
      2'd3:    wdata_rot = {ex_req_i.wdata[7:0], ex_req_i.wdata[31:8]};
      default: wdata_rot = ex_req_i.wdata;
    endcase
  end

  //////////////////////////////
  // Address phase
  //////////////////////////////

  always_comb begin
    bus_trans_o.we    = ex_req_i.we;
    bus_trans_o.wdata = wdata_rot;
    if (split_q) begin
      // Next word, leftover low lanes
      bus_trans_o.addr = word_addr + addr_t'(BYTES_PER_WORD);
      bus_trans_o.be   = be_wide[2*BYTES_PER_WORD-1:BYTES_PER_WORD];
    end else begin
      bus_trans_o.addr = word_addr;
      bus_trans_o.be   = be_wide[BYTES_PER_WORD-1:0];
    end
  end

  // EX holds the access while its second phase is pending
  a_split_req_held : assert property (
    @(posedge clk) disable iff (!rst_n)
    split_q && valid_0_i |-> $stable(ex_req_i)
  );

endmodule

`default_nettype wire

// File: logic/lsu_outstanding_ctrl.sv
// Outstanding transfer control of the load/store unit
// Transfer counter, EX and WB handshakes, busy and interruptible
// Queue of WB control matching responses to their requests
`default_nettype none

module lsu_outstanding_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              valid_0_i,
  input  lsu_pkg::lsu_req_t ex_req_i,
  input  logic              split_i,
  input  lsu_pkg::offset_t  offset_i,
  input  logic              bus_gnt_i,
  input  logic              bus_rvalid_i,
  output logic              bus_req_o,
  output logic              accepted_o,
  output logic              ready_0_o,
  output logic              valid_1_o,
  output logic              busy_o,
  output logic              interruptible_o,
  output lsu_pkg::wb_ctrl_t wb_ctrl_o
);
  import lsu_pkg::*;

  cnt_t                                cnt_q;
  // Request seen without grant in an earlier cycle
  logic                                req_wait_q;
  logic [$clog2(MAX_OUTSTANDING)-1:0]  wr_ptr_q;
  logic [$clog2(MAX_OUTSTANDING)-1:0]  rd_ptr_q;
  wb_ctrl_t                            ctrl_mem [MAX_OUTSTANDING];
  wb_ctrl_t                            ctrl_new;

  //////////////////////////////
  // Handshakes
  //////////////////////////////

  assign bus_req_o  = valid_0_i && (cnt_q < cnt_t'(MAX_OUTSTANDING));
  assign accepted_o = bus_req_o && bus_gnt_i;
  // First phase of a split keeps EX stalled
  assign ready_0_o  = accepted_o && !split_i;
  // WB always takes responses, one pulse per transfer
  assign valid_1_o  = bus_rvalid_i;

  // Up on grant, down on response, both at once cancel
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      case ({accepted_o, bus_rvalid_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  //////////////////////////////
  // WB control queue
  //////////////////////////////

  always_comb begin
    ctrl_new.size   = ex_req_i.size;
    ctrl_new.sext   = ex_req_i.sext;
    ctrl_new.offset = offset_i;
    ctrl_new.last   = !split_i;
    ctrl_new.we     = ex_req_i.we;
  end

  always_ff @(posedge clk) begin
    if (accepted_o) begin
      ctrl_mem[wr_ptr_q] <= ctrl_new;
    end
  end

  // Responses come back in grant order
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (accepted_o) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (bus_rvalid_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  assign wb_ctrl_o = ctrl_mem[rd_ptr_q];

  //////////////////////////////
  // Status
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_wait_q <= 1'b0;
    end else begin
      req_wait_q <= bus_req_o && !bus_gnt_i;
    end
  end

  assign busy_o = (cnt_q != '0) || bus_req_o;
  // First cycle of a request may still be killed
  // once it waits for grant it must complete
  assign interruptible_o = !req_wait_q && (cnt_q == '0);

  a_cnt_limit : assert property (
    @(posedge clk) disable iff (!rst_n)
    cnt_q <= cnt_t'(MAX_OUTSTANDING)
  );

  // OBI address phase may not retract or change before grant
  a_req_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    bus_req_o && !bus_gnt_i |=> bus_req_o && $stable(ex_req_i)
  );

  a_rvalid_has_req : assert property (
    @(posedge clk) disable iff (!rst_n)
    bus_rvalid_i |-> (cnt_q != '0)
  );

endmodule

`default_nettype wire

// File: logic/lsu_rdata_align.sv
// Read data path of the load/store unit
// Keeps the first half of a split load and joins it with the second
// Realigns by byte offset, then zero- or sign-extends by size
`default_nettype none

module lsu_rdata_align (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              bus_rvalid_i,
  input  lsu_pkg::data_t    bus_rdata_i,
  input  lsu_pkg::wb_ctrl_t wb_ctrl_i,
  output lsu_pkg::data_t    rdata_1_o,
  output logic              last_1_o
);
  import lsu_pkg::*;

  // First response of a split access
  data_t               rdata_q;
  // First half held, second half expected
  logic                half_q;
  logic                is_split;
  logic [2*DATA_W-1:0] rdata_full;
  data_t               rdata_aligned;

  assign last_1_o = wb_ctrl_i.last;

  // Same rule as the split detection in EX
  assign is_split = ((wb_ctrl_i.size == SIZE_WORD) && (wb_ctrl_i.offset != '0)) ||
                    ((wb_ctrl_i.size == SIZE_HALF) && (&wb_ctrl_i.offset));

  //////////////////////////////
  // First half capture
  //////////////////////////////

  // Only loads keep their first half
  always_ff @(posedge clk) begin
    if (bus_rvalid_i && !wb_ctrl_i.last && !wb_ctrl_i.we) begin
      rdata_q <= bus_rdata_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      half_q <= 1'b0;
    end else if (bus_rvalid_i) begin
      half_q <= !wb_ctrl_i.last;
    end
  end

  //////////////////////////////
  // Realign and extend
  //////////////////////////////

  // Second word on top of the first
  // unsplit data is doubled so the shift pulls high lanes down
  assign rdata_full = half_q ? {bus_rdata_i, rdata_q} : {bus_rdata_i, bus_rdata_i};

  assign rdata_aligned = data_t'(rdata_full >> {wb_ctrl_i.offset, 3'b000});

  always_comb begin
    case (wb_ctrl_i.size)
      SIZE_BYTE: begin
        rdata_1_o = {{24{wb_ctrl_i.sext && rdata_aligned[7]}}, rdata_aligned[7:0]};
      end
      SIZE_HALF: begin
        rdata_1_o = {{16{wb_ctrl_i.sext && rdata_aligned[15]}}, rdata_aligned[15:0]};
      end
      default: begin
        rdata_1_o = rdata_aligned;
      end
    endcase
  end

  // Final response of a split access must find its first half held
  a_split_joined : assert property (
    @(posedge clk) disable iff (!rst_n)
    bus_rvalid_i && wb_ctrl_i.last && is_split |-> half_q
  );

  // Unsplit access never ends with a stale first half
  a_no_stale_half : assert property (
    @(posedge clk) disable iff (!rst_n)
    bus_rvalid_i && !is_split |-> !half_q && wb_ctrl_i.last
  );

endmodule

`default_nettype wire

// File: logic/lsu_top.sv
// Load/store unit top level
// Request generation, outstanding transfer control and read data alignment
`default_nettype none

module lsu_top (
  input  logic              clk,
  input  logic              rst_n,

  // EX stage
  input  lsu_pkg::lsu_req_t ex_req_i,
  input  logic              valid_0_i,
  output logic              ready_0_o,

  // Bus
  output logic              bus_req_o,
  output lsu_pkg::bus_req_t bus_trans_o,
  input  logic              bus_gnt_i,
  input  logic              bus_rvalid_i,
  input  lsu_pkg::data_t    bus_rdata_i,

  // WB stage
  output logic              valid_1_o,
  output logic              last_1_o,
  output lsu_pkg::data_t    rdata_1_o,

  // Status to the controller
  output logic              busy_o,
  output logic              interruptible_o
);
  import lsu_pkg::*;

  logic     split;
  logic     accepted;
  offset_t  first_offset;
  wb_ctrl_t wb_ctrl;

  // Address, byte enables and write data of the current phase
  lsu_request_gen u_request_gen (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_req_i       (ex_req_i),
    .valid_0_i      (valid_0_i),
    .accepted_i     (accepted),
    .bus_trans_o    (bus_trans_o),
    .split_o        (split),
    .first_offset_o (first_offset)
  );

  // Handshakes, counter and per-transfer WB control
  lsu_outstanding_ctrl u_outstanding_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .valid_0_i       (valid_0_i),
    .ex_req_i        (ex_req_i),
    .split_i         (split),
    .offset_i        (first_offset),
    .bus_gnt_i       (bus_gnt_i),
    .bus_rvalid_i    (bus_rvalid_i),
    .bus_req_o       (bus_req_o),
    .accepted_o      (accepted),
    .ready_0_o       (ready_0_o),
    .valid_1_o       (valid_1_o),
    .busy_o          (busy_o),
    .interruptible_o (interruptible_o),
    .wb_ctrl_o       (wb_ctrl)
  );

  // Response side, joins split loads and extends
  lsu_rdata_align u_rdata_align (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_rdata_i  (bus_rdata_i),
    .wb_ctrl_i    (wb_ctrl),
    .rdata_1_o    (rdata_1_o),
    .last_1_o     (last_1_o)
  );

endmodule

`default_nettype wire

// File: verification/lsu_tb_clock.sv
// Clock and reset source of the testbench
// 8 ns clock, reset held low over the first 3 rising edges
`default_nettype none

module lsu_tb_clock (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam time HALF_PERIOD = 4ns;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Released just after the third rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: verification/lsu_tb.sv
// Testbench top of the load/store unit
// Stimulus table, bus memory model with random grant and response delays
// Compare tasks, status checks, watchdog and summary
`default_nettype none

module lsu_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import lsu_pkg::*;

  // One table row, stimulus and expected results
  typedef struct packed {
    logic  we;
    size_e size;
    logic  sext;
    addr_t op_a;
    addr_t op_b;
    data_t wdata;
    be_t   be0;    // First phase
    be_t   be1;    // Second phase, zero when not split
    data_t rdata;  // Loads only
  } op_t;

  localparam time DRIVE_DLY      = 1ns;
  localparam int  CYCLES_PER_ROW = 40;

  logic     clk;
  logic     rst_n;
  lsu_req_t ex_req;
  logic     valid_0;
  logic     ready_0;
  logic     bus_req;
  bus_req_t bus_trans;
  logic     bus_gnt;
  logic     bus_rvalid;
  data_t    bus_rdata;
  logic     valid_1;
  logic     last_1;
  data_t    rdata_1;
  logic     busy;
  logic     interruptible;

  op_t        ops [$];
  bus_req_t   exp_trans_q [$];
  logic       exp_last_q [$];
  logic       exp_load_q [$];
  data_t      exp_rdata_q [$];
  logic [7:0] shadow_mem [addr_t];
  int         resp_due_q [$];
  data_t      resp_data_q [$];
  int         errors = 0;
  int         checks = 0;
  int         cyc = 0;
  int         gnt_wait = 0;
  int         outstanding = 0;
  int         last_due = 0;
  logic       req_waited = 1'b0;

  lsu_tb_clock u_clock (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  lsu_top uut (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_req_i        (ex_req),
    .valid_0_i       (valid_0),
    .ready_0_o       (ready_0),
    .bus_req_o       (bus_req),
    .bus_trans_o     (bus_trans),
    .bus_gnt_i       (bus_gnt),
    .bus_rvalid_i    (bus_rvalid),
    .bus_rdata_i     (bus_rdata),
    .valid_1_o       (valid_1),
    .last_1_o        (last_1),
    .rdata_1_o       (rdata_1),
    .busy_o          (busy),
    .interruptible_o (interruptible)
  );

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_bus_req(input bus_req_t got, input bus_req_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("error at %0t: bus transfer %h %b %b %h, expected %h %b %b %h", $time,
               got.addr, got.we, got.be, got.wdata, want.addr, want.we, want.be, want.wdata);
    end
  endtask

  task automatic check_rdata(input data_t got, input data_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("error at %0t: load data %h, expected %h", $time, got, want);
    end
  endtask

  task automatic check_level(input logic got, input logic want, input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("error at %0t: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  //////////////////////////////
  // Table and expected phases
  //////////////////////////////

  task automatic add_op(input logic we, input size_e size, input logic sext,
                        input addr_t op_a, input addr_t op_b, input data_t wdata,
                        input be_t be0, input be_t be1, input data_t rdata);
    ops.push_back('{we, size, sext, op_a, op_b, wdata, be0, be1, rdata});
  endtask

  // Unwritten byte at a reads as a times 7 plus 3
  function automatic logic [7:0] read_byte(input addr_t a);
    if (shadow_mem.exists(a)) begin
      return shadow_mem[a];
    end
    return 8'(a * 7 + 3);
  endfunction

  // Word address, enables from the table, register bytes moved up by the offset
  function automatic bus_req_t expected_phase(input op_t op, input int phase);
    addr_t    addr;
    int       off;
    bus_req_t t;
    addr   = op.op_a + op.op_b;
    off    = int'(addr[1:0]);
    t.addr = {addr[31:2], 2'b00} + (phase != 0 ? 32'd4 : 32'd0);
    t.we   = op.we;
    t.be   = (phase != 0) ? op.be1 : op.be0;
    for (int l = 0; l < 4; l++) begin
      t.wdata[8*l +: 8] = op.wdata[8*((l + 4 - off) % 4) +: 8];
    end
    return t;
  endfunction

  task automatic fill_table();
    // we    size       sext  op_a    op_b         wdata         be0      be1      rdata
    add_op(1'b0, SIZE_BYTE, 1'b0, 'h100, 'h10, 'h0, 4'b0001, 4'b0000, 'h00000073);
    add_op(1'b0, SIZE_BYTE, 1'b1, 'h100, 'h13, 'h0, 4'b1000, 4'b0000, 'hFFFFFF88);
    add_op(1'b0, SIZE_BYTE, 1'b0, 'h100, 'h13, 'h0, 4'b1000, 4'b0000, 'h00000088);
    add_op(1'b0, SIZE_HALF, 1'b1, 'h100, 'h20, 'h0, 4'b0011, 4'b0000, 'hFFFFEAE3);
    add_op(1'b0, SIZE_HALF, 1'b0, 'h100, 'h22, 'h0, 4'b1100, 4'b0000, 'h0000F8F1);
    add_op(1'b0, SIZE_WORD, 1'b0, 'h100, 'h30, 'h0, 4'b1111, 4'b0000, 'h68615A53);
    add_op(1'b1, SIZE_WORD, 1'b0, 'h200, 'h0, 'hDEADBEEF, 4'b1111, 4'b0000, 'h0);
    add_op(1'b0, SIZE_WORD, 1'b0, 'h200, 'h0, 'h0, 4'b1111, 4'b0000, 'hDEADBEEF);
    add_op(1'b1, SIZE_BYTE, 1'b0, 'h200, 'h5, 'hA5, 4'b0010, 4'b0000, 'h0);
    add_op(1'b1, SIZE_HALF, 1'b0, 'h200, 'hA, 'h1234, 4'b1100, 4'b0000, 'h0);
    add_op(1'b0, SIZE_WORD, 1'b0, 'h200, 'h4, 'h0, 4'b1111, 4'b0000, 'h342DA51F);
    add_op(1'b0, SIZE_WORD, 1'b0, 'h200, 'h8, 'h0, 4'b1111, 4'b0000, 'h1234423B);
    // Split accesses
    add_op(1'b1, SIZE_WORD, 1'b0, 'h200, 'hD, 'h11223344, 4'b1110, 4'b0001, 'h0);
    add_op(1'b0, SIZE_WORD, 1'b0, 'h200, 'hD, 'h0, 4'b1110, 4'b0001, 'h11223344);
    add_op(1'b0, SIZE_WORD, 1'b0, 'h300, 'h2, 'h0, 4'b1100, 4'b0011, 'h261F1811);
    add_op(1'b0, SIZE_HALF, 1'b1, 'h300, 'h13, 'h0, 4'b1000, 4'b0001, 'hFFFF8F88);
    add_op(1'b0, SIZE_HALF, 1'b1, 'h300, 'h31, 'h0, 4'b0110, 4'b0000, 'h0000615A);
    add_op(1'b1, SIZE_HALF, 1'b0, 'h400, 'hB, 'hBEEF, 4'b1000, 4'b0001, 'h0);
    add_op(1'b0, SIZE_HALF, 1'b1, 'h400, 'hB, 'h0, 4'b1000, 4'b0001, 'hFFFFBEEF);
    add_op(1'b0, SIZE_BYTE, 1'b1, 'h500, 'hFFFFFFFF, 'h0, 4'b1000, 4'b0000, 'hFFFFFFFC);
  endtask

  //////////////////////////////
  // Bus memory model
  //////////////////////////////

  // Called at the falling edge, all levels settled
  task automatic sample_bus();
    bus_req_t want;
    data_t    rword;
    logic     last;
    logic     is_load;
    data_t    exp_rdata;
    int       lat;
    if (outstanding > 0) begin
      check_level(busy, 1'b1, "busy_o with transfers outstanding");
    end
    if (req_waited) begin
      check_level(interruptible, 1'b0, "interruptible_o while waiting for grant");
    end
    check_level(valid_1, bus_rvalid, "valid_1_o against bus response");
    if (bus_rvalid) begin
      outstanding--;
      if (exp_last_q.size() == 0) begin
        errors++;
        $display("Response at %0t came with no transfer in flight", $time);
      end else begin
        last = exp_last_q.pop_front();
        check_level(last_1, last, "last_1_o");
        if (last) begin
          is_load   = exp_load_q.pop_front();
          exp_rdata = exp_rdata_q.pop_front();
          if (is_load) begin
            check_rdata(rdata_1, exp_rdata);
          end
        end
      end
    end
    if (bus_req && bus_gnt) begin
      if (exp_trans_q.size() == 0) begin
        errors++;
        $display("Grant at %0t for a transfer that no table row asked for", $time);
      end else begin
        want = exp_trans_q.pop_front();
        check_bus_req(bus_trans, want);
      end
      // Writes land at grant, read data is taken at grant too
      for (int l = 0; l < 4; l++) begin
        if (bus_trans.we && bus_trans.be[l]) begin
          shadow_mem[bus_trans.addr + addr_t'(l)] = bus_trans.wdata[8*l +: 8];
        end
        rword[8*l +: 8] = read_byte(bus_trans.addr + addr_t'(l));
      end
      outstanding++;
      if (outstanding > MAX_OUTSTANDING) begin
        errors++;
        $display("More than %0d grants unanswered at %0t", MAX_OUTSTANDING, $time);
      end
      // In grant order, 1 to 3 cycles later
      lat      = $urandom_range(3, 1);
      last_due = (cyc + lat > last_due) ? cyc + lat : last_due + 1;
      resp_due_q.push_back(last_due);
      resp_data_q.push_back(rword);
      gnt_wait = $urandom_range(2, 0);
    end else if (bus_req && gnt_wait > 0) begin
      gnt_wait--;
    end
    req_waited = bus_req && !bus_gnt;
  endtask

  // Called just after the rising edge that starts cycle cyc
  task automatic drive_bus();
    cyc++;
    bus_gnt = (gnt_wait == 0);
    if (resp_due_q.size() != 0 && resp_due_q[0] == cyc) begin
      void'(resp_due_q.pop_front());
      bus_rvalid = 1'b1;
      bus_rdata  = resp_data_q.pop_front();
    end else begin
      bus_rvalid = 1'b0;
      bus_rdata  = '0;
    end
  endtask

  initial begin
    forever begin
      @(negedge clk);
      if (rst_n) begin
        sample_bus();
      end
      @(posedge clk);
      #(DRIVE_DLY);
      drive_bus();
    end
  end

  //////////////////////////////
  // Stimulus and summary
  //////////////////////////////

  initial begin
    op_t  op;
    int   n_phases;
    int   row_grants;
    logic done;
    void'($urandom(32'hac3d));
    ex_req     = '0;
    valid_0    = 1'b0;
    bus_gnt    = 1'b0;
    bus_rvalid = 1'b0;
    bus_rdata  = '0;
    fill_table();
    @(posedge rst_n);
    @(negedge clk);
    check_level(bus_req, 1'b0, "bus_req_o after reset");
    check_level(valid_1, 1'b0, "valid_1_o after reset");
    check_level(ready_0, 1'b0, "ready_0_o after reset");
    check_level(busy, 1'b0, "busy_o after reset");
    check_level(interruptible, 1'b1, "interruptible_o after reset");
    @(posedge clk);
    #(DRIVE_DLY);
    for (int i = 0; i < ops.size(); i++) begin
      op       = ops[i];
      ex_req   = '{op.op_a, op.op_b, op.we, op.size, op.sext, op.wdata};
      valid_0  = 1'b1;
      n_phases = (op.be1 != '0) ? 2 : 1;
      exp_trans_q.push_back(expected_phase(op, 0));
      exp_last_q.push_back(n_phases == 1);
      if (n_phases == 2) begin
        exp_trans_q.push_back(expected_phase(op, 1));
        exp_last_q.push_back(1'b1);
      end
      exp_load_q.push_back(!op.we);
      exp_rdata_q.push_back(op.rdata);
      // EX handshake comes with the last grant of the access
      row_grants = 0;
      done       = 1'b0;
      while (!done) begin
        @(negedge clk);
        if (bus_req && bus_gnt) begin
          row_grants++;
        end
        done = ready_0;
      end
      if (row_grants != n_phases) begin
        errors++;
        $display("Row %0d was accepted by EX after %0d grants instead of %0d",
                 i, row_grants, n_phases);
      end
      @(posedge clk);
      #(DRIVE_DLY);
    end
    valid_0 = 1'b0;
    while (exp_last_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(posedge clk);
    $display("Summary: %0d rows, %0d checks, %0d errors", ops.size(), checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    int timeout_ns;
    #(DRIVE_DLY);
    timeout_ns = (ops.size() * CYCLES_PER_ROW + 10) * 8;
    #(timeout_ns);
    $display("Timeout: the run did not finish within %0d ns", timeout_ns);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: lsu_top.f
logic/lsu_pkg.sv
logic/lsu_request_gen.sv
logic/lsu_outstanding_ctrl.sv
logic/lsu_rdata_align.sv
logic/lsu_top.sv
verification/lsu_tb_clock.sv
verification/lsu_tb.sv

// File: Makefile
# Verilator flow for the load/store unit
# Override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR  ?= verilator
FILELIST   ?= lsu_top.f
TB_TOP     ?= lsu_tb
RTL_TOP    ?= lsu_top
TIMESCALE  ?= 1ns/100ps
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_MSG   ?= *** PASSED ***

RTL_SRCS   := $(filter logic/%.sv,$(shell cat $(FILELIST)))
SIM_BIN    := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timescale $(TIMESCALE) \
		--top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) \
		--top-module $(TB_TOP) -f $(FILELIST)

$(SIM_BIN): $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --timescale $(TIMESCALE) --top-module $(TB_TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
		echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
